// ==== verilog/mem_msg_pkg.sv ====
// Memory message definitions
// Field widths and type codes shared by the processor and memory sides

package mem_msg_pkg;

  // ----------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------

  localparam int ADDR_W = 32;   // Byte address
  localparam int DATA_W = 32;   // Processor word
  localparam int LINE_W = 128;  // One cache line, four words
  localparam int OPQ_W  = 8;    // Opaque tag echoed in a response
  localparam int TYPE_W = 3;    // Message type

  // ----------------------------------------------------------
  // Type codes, same in both directions
  // ----------------------------------------------------------

  localparam logic [TYPE_W-1:0] MSG_READ  = 3'd0;
  localparam logic [TYPE_W-1:0] MSG_WRITE = 3'd1;

  // Processor side layout
  //   request  : type, opaque, addr, data (DATA_W)
  //   response : type, opaque, data (DATA_W)
  // A read response carries the word at the request address.
  // A write response carries zero data.

  // Memory side layout
  //   request  : type, addr (line aligned), data (LINE_W)
  //   response : data (LINE_W), read requests only
  // A memory write completes on its request pulse.

  // All accesses are full aligned words, so
  // there is no length field on either side

endpackage

// ==== verilog/cache_cfg_pkg.sv ====
// Cache configuration
// Geometry of the direct-mapped cache, address views and controller state codes

package cache_cfg_pkg;

  // ----------------------------------------------------------
  // Geometry
  // ----------------------------------------------------------

  localparam int NUM_LINES      = 16;
  localparam int IDX_W          = 4;   // Line index
  localparam int OFS_W          = 2;   // Word within line
  localparam int BYTE_W         = 2;   // Byte within word
  localparam int WORDS_PER_LINE = 4;
  localparam int TAG_W          = mem_msg_pkg::ADDR_W - IDX_W - OFS_W - BYTE_W;

  // One address, seen raw or split into its fields
  typedef union packed {
    logic [mem_msg_pkg::ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0]  tag;
      logic [IDX_W-1:0]  idx;
      logic [OFS_W-1:0]  ofs;
      logic [BYTE_W-1:0] byte_ofs;
    } f;
  } cache_addr_u;

  // Controller states
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE        = 3'd0;
  localparam logic [ST_W-1:0] ST_TAG_CHECK   = 3'd1;
  localparam logic [ST_W-1:0] ST_EVICT       = 3'd2;
  localparam logic [ST_W-1:0] ST_REFILL_REQ  = 3'd3;
  localparam logic [ST_W-1:0] ST_REFILL_WAIT = 3'd4;
  localparam logic [ST_W-1:0] ST_ACCESS      = 3'd5;
  localparam logic [ST_W-1:0] ST_RESP        = 3'd6;

endpackage

// ==== verilog/cache_req_decode.sv ====
// Cache request decoder
// Captures an accepted request and presents its address as tag, index and offset

`timescale 1ns/100ps

module cache_req_decode (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cachereq_en,     // Accepted request only
  input  logic [mem_msg_pkg::TYPE_W-1:0]    cachereq_type,
  input  logic [mem_msg_pkg::OPQ_W-1:0]     cachereq_opaque,
  input  logic [mem_msg_pkg::ADDR_W-1:0]    cachereq_addr,
  input  logic [mem_msg_pkg::DATA_W-1:0]    cachereq_data,
  output logic [mem_msg_pkg::TYPE_W-1:0]    req_type,
  output logic [mem_msg_pkg::OPQ_W-1:0]     req_opaque,
  output logic [cache_cfg_pkg::TAG_W-1:0]   req_tag,
  output logic [cache_cfg_pkg::IDX_W-1:0]   req_idx,
  output logic [cache_cfg_pkg::OFS_W-1:0]   req_ofs,
  output logic [mem_msg_pkg::DATA_W-1:0]    req_data
);

  import cache_cfg_pkg::*;

  cache_addr_u addr_q;  // Held request address

  // Request registers, held until the next accepted request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_type   <= '0;
      req_opaque <= '0;
      addr_q     <= '0;
      req_data   <= '0;
    end else if (cachereq_en) begin
      req_type   <= cachereq_type;
      req_opaque <= cachereq_opaque;
      addr_q.raw <= cachereq_addr;
      req_data   <= cachereq_data;
    end
  end

  // ----------------------------------------------------------
  // Field view of the held address
  // ----------------------------------------------------------

  assign req_tag = addr_q.f.tag;
  assign req_idx = addr_q.f.idx;
  assign req_ofs = addr_q.f.ofs;   // Byte offset is ignored, accesses are aligned

endmodule

// ==== verilog/cache_ctrl.sv ====
// Cache controller
// FSM for tag check, write-back, refill, word access and response

`timescale 1ns/100ps

module cache_ctrl (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cachereq_en,
  input  logic [mem_msg_pkg::TYPE_W-1:0]    req_type,
  input  logic                              tag_match,
  input  logic                              line_valid,
  input  logic                              line_dirty,
  input  logic                              memresp_en,
  output logic                              cache_busy,
  output logic                              req_load,
  output logic                              array_wen,
  output logic                              refill_sel,
  output logic                              word_wen,
  output logic                              evict_sel,
  output logic                              read_line_en,
  output logic                              memreq_en,
  output logic [mem_msg_pkg::TYPE_W-1:0]    memreq_type,
  output logic                              cacheresp_en
);

  import mem_msg_pkg::*;
  import cache_cfg_pkg::*;

  logic [ST_W-1:0] state;
  logic [ST_W-1:0] state_next;
  logic            hit;
  logic            is_write;

  assign hit      = tag_match & line_valid;
  assign is_write = (req_type == MSG_WRITE);

  // ----------------------------------------------------------
  // State register
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (cachereq_en) begin
          state_next = ST_TAG_CHECK;
        end
      end
      ST_TAG_CHECK: begin
        if (hit) begin
          state_next = ST_ACCESS;
        end else if (line_valid && line_dirty) begin
          state_next = ST_EVICT;      // Victim must go back first
        end else begin
          state_next = ST_REFILL_REQ;
        end
      end
      ST_EVICT: begin
        state_next = ST_REFILL_REQ;   // Write completes on its pulse
      end
      ST_REFILL_REQ: begin
        state_next = ST_REFILL_WAIT;
      end
      ST_REFILL_WAIT: begin
        if (memresp_en) begin
          state_next = ST_ACCESS;
        end
      end
      ST_ACCESS: begin
        state_next = ST_RESP;
      end
      ST_RESP: begin
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------

  assign cache_busy = (state != ST_IDLE);
  assign req_load   = cachereq_en & (state == ST_IDLE);  // Pulses while busy are dropped

  // Refill writes the line in the cycle memory answers
  assign refill_sel = (state == ST_REFILL_WAIT);
  assign array_wen  = refill_sel & memresp_en;

  assign word_wen     = (state == ST_ACCESS) & is_write;
  assign read_line_en = (state == ST_ACCESS) & ~is_write;

  // Memory side, write-back then refill read
  assign evict_sel   = (state == ST_EVICT);
  assign memreq_en   = evict_sel | (state == ST_REFILL_REQ);
  assign memreq_type = evict_sel ? MSG_WRITE : MSG_READ;

  assign cacheresp_en = (state == ST_RESP);

endmodule

// ==== verilog/cache_dpath.sv ====
// Cache datapath
// Tag, valid, dirty and data arrays with refill, word merge and memory request forming

`timescale 1ns/100ps

module cache_dpath (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [cache_cfg_pkg::TAG_W-1:0]   req_tag,
  input  logic [cache_cfg_pkg::IDX_W-1:0]   req_idx,
  input  logic [cache_cfg_pkg::OFS_W-1:0]   req_ofs,
  input  logic [mem_msg_pkg::DATA_W-1:0]    req_data,
  input  logic [mem_msg_pkg::LINE_W-1:0]    memresp_data,
  input  logic                              array_wen,
  input  logic                              refill_sel,
  input  logic                              word_wen,
  input  logic                              evict_sel,
  output logic                              tag_match,
  output logic                              line_valid,
  output logic                              line_dirty,
  output logic [mem_msg_pkg::LINE_W-1:0]    cache_line,
  output logic [mem_msg_pkg::ADDR_W-1:0]    memreq_addr,
  output logic [mem_msg_pkg::LINE_W-1:0]    memreq_data
);

  import mem_msg_pkg::*;
  import cache_cfg_pkg::*;

  logic [TAG_W-1:0]     tag_array  [NUM_LINES];
  logic [LINE_W-1:0]    data_array [NUM_LINES];
  logic [NUM_LINES-1:0] valid_bits;
  logic [NUM_LINES-1:0] dirty_bits;

  logic [TAG_W-1:0]     stored_tag;
  logic [LINE_W-1:0]    merged_line;
  logic [LINE_W-1:0]    write_line;
  logic                 data_wen;
  cache_addr_u          evict_addr;
  cache_addr_u          refill_addr;

  // Combinational lookup at the request index
  assign stored_tag = tag_array[req_idx];
  assign cache_line = data_array[req_idx];
  assign tag_match  = (stored_tag == req_tag);
  assign line_valid = valid_bits[req_idx];
  assign line_dirty = dirty_bits[req_idx];

  // Replace only the addressed word
  always_comb begin
    merged_line = cache_line;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      if (w == int'(req_ofs)) begin
        merged_line[w*DATA_W +: DATA_W] = req_data;
      end
    end
  end

  assign write_line = refill_sel ? memresp_data : merged_line;
  assign data_wen   = array_wen | word_wen;

  // ----------------------------------------------------------
  // Array writes
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (data_wen) begin
      data_array[req_idx] <= write_line;
    end
    if (array_wen) begin
      tag_array[req_idx] <= req_tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (array_wen) begin
      valid_bits[req_idx] <= 1'b1;   // Fresh line is clean
      dirty_bits[req_idx] <= 1'b0;
    end else if (word_wen) begin
      dirty_bits[req_idx] <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Memory request, line aligned
  // ----------------------------------------------------------

  always_comb begin
    evict_addr.f.tag       = stored_tag;   // Victim lives at the old tag
    evict_addr.f.idx       = req_idx;
    evict_addr.f.ofs       = '0;
    evict_addr.f.byte_ofs  = '0;
    refill_addr.f.tag      = req_tag;
    refill_addr.f.idx      = req_idx;
    refill_addr.f.ofs      = '0;
    refill_addr.f.byte_ofs = '0;
  end

  assign memreq_addr = evict_sel ? evict_addr.raw : refill_addr.raw;
  assign memreq_data = cache_line;  // Used by write-back only

endmodule

// ==== verilog/cache_resp.sv ====
// Cache response block
// Holds the read line and builds the response word, type and opaque tag

`timescale 1ns/100ps

module cache_resp (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              read_line_en,
  input  logic [mem_msg_pkg::LINE_W-1:0]    cache_line,
  input  logic [cache_cfg_pkg::OFS_W-1:0]   req_ofs,
  input  logic [mem_msg_pkg::TYPE_W-1:0]    req_type,
  input  logic [mem_msg_pkg::OPQ_W-1:0]     req_opaque,
  output logic [mem_msg_pkg::TYPE_W-1:0]    cacheresp_type,
  output logic [mem_msg_pkg::OPQ_W-1:0]     cacheresp_opaque,
  output logic [mem_msg_pkg::DATA_W-1:0]    cacheresp_data
);

  import mem_msg_pkg::*;

  logic [LINE_W-1:0] line_q;
  logic [DATA_W-1:0] read_word;

  // Line register, loaded in the access cycle of a read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_q <= '0;
    end else if (read_line_en) begin
      line_q <= cache_line;
    end
  end

  assign read_word = line_q[req_ofs*DATA_W +: DATA_W];

  // ----------------------------------------------------------
  // Response fields
  // ----------------------------------------------------------

  assign cacheresp_type   = req_type;
  assign cacheresp_opaque = req_opaque;
  assign cacheresp_data   = (req_type == MSG_WRITE) ? '0 : read_word;  // Writes return zero

endmodule

// ==== verilog/blocking_cache.sv ====
// Blocking cache top level
// 256-byte direct-mapped write-back cache built from decoder, FSM, datapath and response

`timescale 1ns/100ps

module blocking_cache (
  input  logic                              clk,
  input  logic                              rst_n,
  // Processor request
  input  logic                              cachereq_en,
  input  logic [mem_msg_pkg::TYPE_W-1:0]    cachereq_type,
  input  logic [mem_msg_pkg::OPQ_W-1:0]     cachereq_opaque,
  input  logic [mem_msg_pkg::ADDR_W-1:0]    cachereq_addr,
  input  logic [mem_msg_pkg::DATA_W-1:0]    cachereq_data,
  output logic                              cache_busy,
  // Processor response
  output logic                              cacheresp_en,
  output logic [mem_msg_pkg::TYPE_W-1:0]    cacheresp_type,
  output logic [mem_msg_pkg::OPQ_W-1:0]     cacheresp_opaque,
  output logic [mem_msg_pkg::DATA_W-1:0]    cacheresp_data,
  // Memory side
  output logic                              memreq_en,
  output logic [mem_msg_pkg::TYPE_W-1:0]    memreq_type,
  output logic [mem_msg_pkg::ADDR_W-1:0]    memreq_addr,
  output logic [mem_msg_pkg::LINE_W-1:0]    memreq_data,
  input  logic                              memresp_en,
  input  logic [mem_msg_pkg::LINE_W-1:0]    memresp_data
);

  import mem_msg_pkg::*;
  import cache_cfg_pkg::*;

  // ----------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------

  logic [TYPE_W-1:0] req_type;
  logic [OPQ_W-1:0]  req_opaque;
  logic [TAG_W-1:0]  req_tag;
  logic [IDX_W-1:0]  req_idx;
  logic [OFS_W-1:0]  req_ofs;
  logic [DATA_W-1:0] req_data;
  logic              req_load;
  logic              tag_match;
  logic              line_valid;
  logic              line_dirty;
  logic [LINE_W-1:0] cache_line;
  logic              array_wen;
  logic              refill_sel;
  logic              word_wen;
  logic              evict_sel;
  logic              read_line_en;

  // Decoder only sees requests the FSM accepts
  cache_req_decode i_req_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .cachereq_en     (req_load),
    .cachereq_type   (cachereq_type),
    .cachereq_opaque (cachereq_opaque),
    .cachereq_addr   (cachereq_addr),
    .cachereq_data   (cachereq_data),
    .req_type        (req_type),
    .req_opaque      (req_opaque),
    .req_tag         (req_tag),
    .req_idx         (req_idx),
    .req_ofs         (req_ofs),
    .req_data        (req_data)
  );

  cache_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cachereq_en  (cachereq_en),
    .req_type     (req_type),
    .tag_match    (tag_match),
    .line_valid   (line_valid),
    .line_dirty   (line_dirty),
    .memresp_en   (memresp_en),
    .cache_busy   (cache_busy),
    .req_load     (req_load),
    .array_wen    (array_wen),
    .refill_sel   (refill_sel),
    .word_wen     (word_wen),
    .evict_sel    (evict_sel),
    .read_line_en (read_line_en),
    .memreq_en    (memreq_en),
    .memreq_type  (memreq_type),
    .cacheresp_en (cacheresp_en)
  );

  cache_dpath i_dpath (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_tag      (req_tag),
    .req_idx      (req_idx),
    .req_ofs      (req_ofs),
    .req_data     (req_data),
    .memresp_data (memresp_data),
    .array_wen    (array_wen),
    .refill_sel   (refill_sel),
    .word_wen     (word_wen),
    .evict_sel    (evict_sel),
    .tag_match    (tag_match),
    .line_valid   (line_valid),
    .line_dirty   (line_dirty),
    .cache_line   (cache_line),
    .memreq_addr  (memreq_addr),
    .memreq_data  (memreq_data)
  );

  cache_resp i_resp (
    .clk              (clk),
    .rst_n            (rst_n),
    .read_line_en     (read_line_en),
    .cache_line       (cache_line),
    .req_ofs          (req_ofs),
    .req_type         (req_type),
    .req_opaque       (req_opaque),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
// Testbench clock source
// Free-running clock with a 100 ns period

`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;  // Half period

endmodule

// ==== sim/tb_blocking_cache.sv ====
// Testbench for the blocking cache
// Memory model, reference cache model, directed and random traffic, checker and watchdog

`timescale 1ns/100ps

module tb_blocking_cache;

  import mem_msg_pkg::*;

  localparam int NUM_REQ   = 312;                // Directed plus random requests
  localparam int WD_CYCLES = NUM_REQ * 20 + 200;

  logic clk, rst_n;
  logic cachereq_en, cache_busy, cacheresp_en, memreq_en, memresp_en;
  logic [TYPE_W-1:0] cachereq_type, cacheresp_type, memreq_type;
  logic [OPQ_W-1:0]  cachereq_opaque, cacheresp_opaque;
  logic [ADDR_W-1:0] cachereq_addr, memreq_addr;
  logic [DATA_W-1:0] cachereq_data, cacheresp_data;
  logic [LINE_W-1:0] memreq_data, memresp_data;

  logic [127:0] mem_line [64];      // 1 KB backing memory
  logic [31:0]  ref_mem  [256];     // Word view seen by the processor
  logic [23:0]  ref_tag  [16];
  bit           ref_valid [16];
  bit           ref_dirty [16];
  logic [2:0]   mq_type[$];
  logic [31:0]  mq_addr[$];
  logic [127:0] mq_data[$];
  logic [2:0]   rq_type[$];
  logic [7:0]   rq_opq[$];
  logic [31:0]  rq_data[$];
  int           rq_lat[$];
  int cycle = 0, req_cycle = 0, resp_count = 0, errors = 0;
  int tests_run = 0, tests_failed = 0, pend_cnt = 0;
  logic [31:0] pend_addr;

  tb_clock_gen i_clk (.clk(clk));

  blocking_cache i_blocking_cache (.*);

  always @(posedge clk) cycle <= cycle + 1;

  // Fill pattern that depends on the whole byte address
  function automatic logic [31:0] init_word(input logic [31:0] a);
    return (a * 32'h0001_0003) ^ 32'h5a5a_0f0f;
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Direct-mapped write-back model of one access
  function automatic void ref_cache_access(input logic [2:0] t, input logic [31:0] a,
      input logic [31:0] d, output logic [31:0] rdata, output logic miss, output logic wb,
      output logic [31:0] wb_addr, output logic [127:0] wb_line);
    logic [3:0]  idx;
    logic [23:0] tag;
    int          base;
    idx     = a[7:4];
    tag     = a[31:8];
    miss    = !(ref_valid[idx] && ref_tag[idx] == tag);
    wb      = miss && ref_valid[idx] && ref_dirty[idx];
    wb_addr = {ref_tag[idx], idx, 4'h0};
    base    = int'({ref_tag[idx][1:0], idx, 2'b00});
    wb_line = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    if (miss) begin
      ref_tag[idx]   = tag;
      ref_valid[idx] = 1'b1;
      ref_dirty[idx] = 1'b0;
    end
    if (t == MSG_WRITE) begin
      ref_mem[a[9:2]] = d;
      ref_dirty[idx]  = 1'b1;
      rdata           = '0;
    end else begin
      rdata = ref_mem[a[9:2]];
    end
  endfunction

  // ----------------------------------------------------------
  // Memory model that answers reads after 1 to 4 cycles
  // ----------------------------------------------------------

  always @(posedge clk) begin
    memresp_en <= 1'b0;
    if (memreq_en && memreq_type == MSG_WRITE) begin
      mem_line[memreq_addr[9:4]] <= memreq_data;   // Write-back lands at once
    end else if (memreq_en) begin
      pend_addr <= memreq_addr;
      pend_cnt  <= int'($urandom_range(1, 4));
    end else if (pend_cnt != 0) begin
      if (pend_cnt == 1) begin
        memresp_en   <= 1'b1;
        memresp_data <= mem_line[pend_addr[9:4]];
      end
      pend_cnt <= pend_cnt - 1;
    end
  end

  // ----------------------------------------------------------
  // Compare process
  // ----------------------------------------------------------

  always @(posedge clk) begin
    if (rst_n && memreq_en) begin
      if (mq_type.size() == 0) begin
        $display("Error at %0t: memory request %h with none expected", $time, memreq_addr);
        errors++;
      end else begin
        check_value("memreq_type", 128'(mq_type[0]), 128'(memreq_type));
        check_value("memreq_addr", 128'(mq_addr[0]), 128'(memreq_addr));
        if (mq_type[0] == MSG_WRITE) check_value("memreq_data", mq_data[0], memreq_data);
        void'(mq_type.pop_front());
        void'(mq_addr.pop_front());
        void'(mq_data.pop_front());
      end
    end
    if (rst_n && cacheresp_en) begin
      if (rq_type.size() == 0) begin
        $display("Error at %0t: response with no request outstanding", $time);
        errors++;
      end else begin
        check_value("cacheresp_type", 128'(rq_type[0]), 128'(cacheresp_type));
        check_value("cacheresp_opaque", 128'(rq_opq[0]), 128'(cacheresp_opaque));
        check_value("cacheresp_data", 128'(rq_data[0]), 128'(cacheresp_data));
        // A hit shows up at the third edge after the request is sampled
        if (rq_lat[0] != 0) check_value("hit latency", 128'(rq_lat[0]), 128'(cycle - req_cycle));
        void'(rq_type.pop_front());
        void'(rq_opq.pop_front());
        void'(rq_data.pop_front());
        void'(rq_lat.pop_front());
      end
      resp_count <= resp_count + 1;
    end
  end

  task automatic send_req(input logic [2:0] t, input logic [31:0] a, input logic [31:0] d,
      input logic [7:0] opq);
    logic [31:0]  rdata, wb_addr;
    logic [127:0] wb_line;
    logic         miss, wb;
    int           start, wait_cnt;
    ref_cache_access(t, a, d, rdata, miss, wb, wb_addr, wb_line);
    if (wb) begin
      mq_type.push_back(MSG_WRITE);
      mq_addr.push_back(wb_addr);
      mq_data.push_back(wb_line);
    end
    if (miss) begin
      mq_type.push_back(MSG_READ);
      mq_addr.push_back({a[31:4], 4'h0});
      mq_data.push_back('0);
    end
    rq_type.push_back(t);
    rq_opq.push_back(opq);
    rq_data.push_back(rdata);
    rq_lat.push_back(miss ? 0 : 3);
    @(posedge clk);
    while (cache_busy) @(posedge clk);
    cachereq_en     <= 1'b1;
    cachereq_type   <= t;
    cachereq_addr   <= a;
    cachereq_data   <= d;
    cachereq_opaque <= opq;
    @(posedge clk);
    req_cycle   = cycle;
    cachereq_en <= 1'b0;
    start    = resp_count;
    wait_cnt = 0;
    while (resp_count == start && wait_cnt < 40) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (resp_count == start) begin
      $display("Error at %0t: no response for address %h", $time, a);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL", name);
    end
  endtask

  // Watchdog
  initial begin
    #(WD_CYCLES * 100);
    $display("Watchdog expired after %0d cycles, the run is stuck", WD_CYCLES);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int e;
    void'($urandom(32'h0270_1a02));
    for (int i = 0; i < 256; i++) ref_mem[i] = init_word(32'(i * 4));
    for (int i = 0; i < 64; i++) begin
      mem_line[i] = {init_word(32'(i*16+12)), init_word(32'(i*16+8)),
                     init_word(32'(i*16+4)), init_word(32'(i*16))};
    end
    rst_n           = 1'b0;
    cachereq_en     = 1'b0;
    cachereq_type   = '0;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    memresp_en      = 1'b0;
    memresp_data    = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    e = errors;    // Idle outputs after reset and a cold miss
    repeat (10) begin
      @(posedge clk);
      check_value("cacheresp_en", 128'(0), 128'(cacheresp_en));
      check_value("memreq_en", 128'(0), 128'(memreq_en));
      check_value("cache_busy", 128'(0), 128'(cache_busy));
    end
    send_req(MSG_READ, 32'h000, '0, 8'h01);
    end_test("reset", e);

    e = errors;
    send_req(MSG_READ, 32'h010, '0, 8'h02);
    send_req(MSG_READ, 32'h014, '0, 8'h03);
    end_test("read miss then hit", e);

    e = errors;    // Line 0x010 is resident from the previous test
    send_req(MSG_WRITE, 32'h014, 32'hcafe_f00d, 8'h04);
    for (int w = 0; w < 4; w++) send_req(MSG_READ, 32'(32'h010 + w * 4), '0, 8'(5 + w));
    end_test("write hit then read", e);

    e = errors;
    send_req(MSG_WRITE, 32'h048, 32'h1234_5678, 8'h10);
    send_req(MSG_READ, 32'h148, '0, 8'h11);
    end_test("dirty eviction", e);

    e = errors;
    send_req(MSG_WRITE, 32'h050, 32'hdead_beef, 8'ha5);
    send_req(MSG_READ, 32'h050, '0, 8'h3c);
    end_test("echo", e);

    e = errors;
    for (int i = 0; i < 300; i++) begin
      send_req(($urandom_range(0, 1) == 1) ? MSG_WRITE : MSG_READ,
               {22'd0, 8'($urandom_range(0, 255)), 2'b00}, $urandom, 8'($urandom));
    end
    repeat (5) @(posedge clk);
    if (mq_type.size() != 0 || rq_type.size() != 0) begin
      $display("Error at %0t: expected memory requests or responses never arrived", $time);
      errors++;
    end
    end_test("random traffic", e);

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/mem_msg_pkg.sv
verilog/cache_cfg_pkg.sv
verilog/cache_req_decode.sv
verilog/cache_ctrl.sv
verilog/cache_dpath.sv
verilog/cache_resp.sv
verilog/blocking_cache.sv
sim/tb_clock_gen.sv
sim/tb_blocking_cache.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_blocking_cache
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
